/* spi_timing_pkg.sv */
`default_nettype none

package spi_timing_pkg;

   // engine sequencing
   typedef enum logic [1:0] {
      st_idle    = 2'd0,  // ss high, waiting for a byte
      st_shift   = 2'd1,  // byte on the wire
      st_hold    = 2'd2,  // ss low between the two bytes of a pair
      st_release = 2'd3   // single cycle, raises ss
   } engine_state_t;

   localparam int clk_div_max = 3;  // sclk half period up to 16 SCK cycles
   localparam int div_cnt_w   = 5;  // holds a count of 16

   // half period of sclk in SCK cycles, 2**(div+1), out-of-range div clamped
   function automatic int half_period_of(int div);
      int d;
      d = (div > clk_div_max) ? clk_div_max : div;
      if (d < 0) d = 0;
      return 2 ** (d + 1);
   endfunction

endpackage

`default_nettype wire

/* spi_data_pkg.sv */
`default_nettype none

package spi_data_pkg;

   //////////////////////////////////////////////////////////////////////
   // serial payload
   //////////////////////////////////////////////////////////////////////

   typedef logic [7:0] spi_byte_t;  // one byte on mosi or miso

   localparam int byte_bits = $bits(spi_byte_t);  // bits per transfer
   localparam int bit_cnt_w = 4;                  // counts 0..8

   //////////////////////////////////////////////////////////////////////
   // idle line levels
   //////////////////////////////////////////////////////////////////////

   localparam logic mosi_idle = 1'b1;  // mosi parked high
   localparam logic sclk_idle = 1'b1;  // mode 3, clock idles high
   localparam logic ss_idle   = 1'b1;  // select inactive

   // shift register fill, keeps mosi at its idle level once the byte is out
   localparam spi_byte_t idle_byte = {byte_bits{mosi_idle}};

endpackage

`default_nettype wire

/* spi_tx_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_tx_stage
   import spi_data_pkg::*;
(
   input  logic      SCK,
   input  logic      clr,
   input  logic      start,       // one-cycle strobe with tx_data
   input  spi_byte_t tx_data,
   input  logic      take,        // engine copies pend_byte this cycle
   output logic      pend_valid,
   output spi_byte_t pend_byte,
   output logic      busy
);

   logic accept;  // start that the buffer takes

   //////////////////////////////////////////////////////////////////////
   // user side
   //////////////////////////////////////////////////////////////////////

   // a take frees the slot in the same cycle, so a start
   // landing on take refills it directly
   assign busy   = pend_valid & ~take;
   assign accept = start & ~busy;  // start while busy is dropped

   //////////////////////////////////////////////////////////////////////
   // one-entry buffer
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge SCK or posedge clr) begin
      if (clr) begin
         pend_valid <= 1'b0;
      end else begin
         if (accept) begin
            pend_valid <= 1'b1;  // new byte, also when replacing on take
         end else if (take) begin
            pend_valid <= 1'b0;  // engine has it
         end
      end
   end

   always_ff @(posedge SCK) begin
      if (accept) begin
         pend_byte <= tx_data;  // payload, no reset
      end
   end

endmodule

`default_nettype wire

/* spi_shift_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_shift_engine
   import spi_timing_pkg::*;
   import spi_data_pkg::*;
#(
   parameter int clk_div   = 0,     // sclk half period is 2**(clk_div+1)
   parameter bit msb_first = 1'b1,  // 1 msb first, 0 lsb first
   parameter bit pair_mode = 1'b1   // keep ss low over two bytes
) (
   input  logic      SCK,
   input  logic      clr,
   input  logic      pend_valid,
   input  spi_byte_t pend_byte,
   output logic      take,          // one-cycle pulse, byte copied
   input  logic      miso,
   output logic      ss,
   output logic      sclk,
   output logic      mosi,
   output logic      sample_pulse,  // on each rising sclk
   output logic      miso_bit,
   output logic      byte_end       // with the eighth rising sclk
);

   localparam int half_period = half_period_of(clk_div);
   localparam logic [div_cnt_w-1:0] div_last = div_cnt_w'(half_period - 1);
   localparam logic [bit_cnt_w-1:0] last_bit = bit_cnt_w'(byte_bits - 1);

   engine_state_t          state;
   logic [div_cnt_w-1:0]   div_cnt;     // SCK cycles into the half period
   logic [bit_cnt_w-1:0]   bit_cnt;     // rising edges so far
   spi_byte_t              tx_shreg;
   spi_byte_t              tx_shifted;
   logic                   pair_first;  // current byte opens a pair
   logic                   half_done;

   //////////////////////////////////////////////////////////////////////
   // transmit shift register
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      if (msb_first) begin
         tx_shifted = {tx_shreg[byte_bits-2:0], mosi_idle};  // fill from lsb
      end else begin
         tx_shifted = {mosi_idle, tx_shreg[byte_bits-1:1]};  // fill from msb
      end
   end

   assign mosi      = msb_first ? tx_shreg[byte_bits-1] : tx_shreg[0];
   assign half_done = (div_cnt == div_last);  // sclk toggles after this cycle

   //////////////////////////////////////////////////////////////////////
   // sequencer, divider and bit counter
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge SCK or posedge clr) begin
      if (clr) begin
         state        <= st_idle;
         div_cnt      <= '0;
         bit_cnt      <= '0;
         pair_first   <= 1'b0;
         take         <= 1'b0;
         ss           <= ss_idle;
         sclk         <= sclk_idle;
         sample_pulse <= 1'b0;
         miso_bit     <= 1'b0;
         byte_end     <= 1'b0;
         tx_shreg     <= idle_byte;  // mosi high out of reset
      end else begin
         take         <= 1'b0;  // pulses
         sample_pulse <= 1'b0;
         byte_end     <= 1'b0;
         case (state)
            st_idle, st_hold: begin
               if (pend_valid) begin
                  take       <= 1'b1;
                  ss         <= ~ss_idle;   // no-op when coming from hold
                  tx_shreg   <= pend_byte;  // first bit on mosi with take
                  div_cnt    <= '0;
                  bit_cnt    <= '0;
                  pair_first <= pair_mode && (state == st_idle);
                  state      <= st_shift;
               end
            end
            st_shift: begin
               if (half_done) begin
                  div_cnt <= '0;
                  sclk    <= ~sclk;
                  if (sclk) begin
                     // falling edge, first one keeps the bit set up at take
                     if (bit_cnt != '0) begin
                        tx_shreg <= tx_shifted;
                     end
                  end else begin
                     // rising edge, slave data is stable here
                     sample_pulse <= 1'b1;
                     miso_bit     <= miso;
                     bit_cnt      <= bit_cnt + 1'b1;
                     if (bit_cnt == last_bit) begin
                        byte_end <= 1'b1;
                        state    <= pair_first ? st_hold : st_release;
                     end
                  end
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            st_release: begin
               ss       <= ss_idle;
               tx_shreg <= idle_byte;  // mosi back to idle with ss
               state    <= st_idle;
            end
            default: state <= st_release;
         endcase
      end
   end

endmodule

`default_nettype wire

/* spi_rx_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_rx_stage
   import spi_data_pkg::*;
#(
   parameter bit msb_first = 1'b1  // first bit received lands in the msb
) (
   input  logic      SCK,
   input  logic      clr,
   input  logic      sample_pulse,
   input  logic      miso_bit,
   input  logic      byte_end,  // comes with the last sample_pulse
   output spi_byte_t rx_data,
   output logic      done
);

   spi_byte_t rx_shreg;
   spi_byte_t rx_next;  // shreg incl. this cycle's bit

   always_comb begin
      rx_next = rx_shreg;
      if (sample_pulse) begin
         if (msb_first) begin
            rx_next = {rx_shreg[byte_bits-2:0], miso_bit};  // shift left
         end else begin
            rx_next = {miso_bit, rx_shreg[byte_bits-1:1]};  // shift right
         end
      end
   end

   always_ff @(posedge SCK) begin
      if (byte_end) begin
         rx_shreg <= '0;  // next byte starts clean
      end else begin
         rx_shreg <= rx_next;
      end
   end

   // holding register and done strobe
   always_ff @(posedge SCK or posedge clr) begin
      if (clr) begin
         rx_data <= '0;
         done    <= 1'b0;
      end else begin
         done <= byte_end;
         if (byte_end) begin
            rx_data <= rx_next;  // eighth bit included
         end
      end
   end

endmodule

`default_nettype wire

/* spi_mode3_top.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_mode3_top
   import spi_data_pkg::*;
#(
   parameter int clk_div   = 1,     // 0..3, sclk half period 2..16 SCK
   parameter bit msb_first = 1'b1,
   parameter bit pair_mode = 1'b1   // two bytes per ss frame
) (
   input  logic      SCK,
   input  logic      clr,
   // user side
   input  logic      start,
   input  spi_byte_t tx_data,
   output logic      busy,
   output logic      done,
   output spi_byte_t rx_data,
   // spi bus
   output logic      ss,
   output logic      sclk,
   output logic      mosi,
   input  logic      miso
);

   logic      pend_valid;
   spi_byte_t pend_byte;
   logic      take;
   logic      sample_pulse;
   logic      miso_bit;
   logic      byte_end;

   //////////////////////////////////////////////////////////////////////
   // input side
   //////////////////////////////////////////////////////////////////////

   spi_tx_stage tx_stage_i (
      .SCK        (SCK),
      .clr        (clr),
      .start      (start),
      .tx_data    (tx_data),
      .take       (take),
      .pend_valid (pend_valid),
      .pend_byte  (pend_byte),
      .busy       (busy)
   );

   //////////////////////////////////////////////////////////////////////
   // serial engine
   //////////////////////////////////////////////////////////////////////

   spi_shift_engine #(
      .clk_div   (clk_div),
      .msb_first (msb_first),
      .pair_mode (pair_mode)
   ) engine_i (
      .SCK          (SCK),
      .clr          (clr),
      .pend_valid   (pend_valid),
      .pend_byte    (pend_byte),
      .take         (take),
      .miso         (miso),
      .ss           (ss),
      .sclk         (sclk),
      .mosi         (mosi),
      .sample_pulse (sample_pulse),
      .miso_bit     (miso_bit),
      .byte_end     (byte_end)
   );

   //////////////////////////////////////////////////////////////////////
   // output side
   //////////////////////////////////////////////////////////////////////

   spi_rx_stage #(
      .msb_first (msb_first)
   ) rx_stage_i (
      .SCK          (SCK),
      .clr          (clr),
      .sample_pulse (sample_pulse),
      .miso_bit     (miso_bit),
      .byte_end     (byte_end),
      .rx_data      (rx_data),
      .done         (done)
   );

endmodule

`default_nettype wire

/* spi_slave_model.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_slave_model
   import spi_data_pkg::*;
#(
   parameter logic [31:0] seed = 32'h1  // miso byte stream
) (
   input  logic SCK,   // idle check only
   input  logic ss,
   input  logic sclk,
   input  logic mosi,
   output logic miso
);

   spi_byte_t   mosi_log [$];          // collected from mosi in order
   spi_byte_t   miso_log [$];          // driven on miso in order
   int          mosi_cnt    = 0;
   int          miso_cnt    = 0;
   int          idle_errors = 0;
   logic [31:0] rng         = seed;
   spi_byte_t   tx_sh;                 // msb goes out on miso
   spi_byte_t   rx_sh;                 // mosi bits in msb first order
   int          rises       = 0;       // rising sclk edges in this byte
   logic        reload      = 1'b0;    // fetch next byte on the next fall
   logic        ss_q        = 1'b1;
   logic        sclk_q      = 1'b1;
   logic        miso_r      = 1'b1;    // drives miso and starts high

   assign miso = miso_r;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   task automatic load_byte();
      rng = xorshift32(rng);
      tx_sh = rng[7:0];
      miso_log.push_back(tx_sh);
      miso_cnt = miso_cnt + 1;
      miso_r = tx_sh[7];  // first bit ready before the first rise
      rises  = 0;
      reload = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // mode 3 slave shifts out on fall and samples on rise
   //////////////////////////////////////////////////////////////////////

   always @(posedge ss or negedge ss or posedge sclk or negedge sclk) begin
      if (ss_q && !ss) begin
         load_byte();  // frame opens
      end else if (!ss && sclk && !sclk_q) begin
         rx_sh = {rx_sh[6:0], mosi};
         rises = rises + 1;
         if (rises == 8) begin
            mosi_log.push_back(rx_sh);
            mosi_cnt = mosi_cnt + 1;
            reload   = 1'b1;  // second byte of a pair follows if ss stays low
         end
      end else if (!ss && !sclk && sclk_q) begin
         if (reload) begin
            load_byte();
         end else if (rises != 0) begin
            tx_sh  = {tx_sh[6:0], 1'b1};
            miso_r = tx_sh[7];
         end
      end
      ss_q   = ss;
      sclk_q = sclk;
   end

   // mosi parked while deselected
   always @(negedge SCK) begin
      if (ss === 1'b1) begin
         assert (mosi === mosi_idle) else begin
            idle_errors = idle_errors + 1;
            $display("FAILED at %0t ns: mosi %b while ss is high", $time, mosi);
         end
      end
   end

endmodule

`default_nettype wire

/* tb_spi_mode3.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_spi_mode3
   import spi_data_pkg::*;
();

   localparam int          n_bytes    = 40;
   localparam int          sclk_half  = 4;  // clk_div 1
   localparam int          wd_cycles  = n_bytes * (16 * sclk_half + 10) + 200;
   localparam logic [31:0] seed       = 32'h658a_6d88;

   logic        SCK     = 1'b0;
   logic        clr     = 1'b1;
   logic        start   = 1'b0;
   spi_byte_t   tx_data = '0;
   logic        busy;
   logic        done;
   logic        ss;
   logic        sclk;
   logic        mosi;
   logic        miso;
   spi_byte_t   rx_data;

   logic [31:0] rng       = seed;
   spi_byte_t   tx_q [$];      // accepted bytes with the oldest first
   int          errors    = 0;
   int          sent      = 0;
   int          done_cnt  = 0;
   int          ss_falls  = 0;
   int          ss_rises  = 0;
   int          rise_cnt  = 0;  // all rising sclk edges
   int          level_len = 0;
   int          cyc       = 0;
   int          fall_at   = 0;
   logic        clr_p     = 1'b1;
   logic        ss_p      = 1'b1;
   logic        sclk_p    = 1'b1;
   logic        mosi_p    = 1'b1;
   logic        done_p    = 1'b0;
   logic        high_mid  = 1'b0;  // high level inside a byte
   logic        gap_ok    = 1'b1;  // take may move mosi between bytes
   logic        fall_wait = 1'b0;

   always #4 SCK = ~SCK;  // 8 ns

   spi_mode3_top #(.clk_div(1), .msb_first(1'b1), .pair_mode(1'b1)) dut_i (
      .SCK(SCK), .clr(clr), .start(start), .tx_data(tx_data), .busy(busy),
      .done(done), .rx_data(rx_data), .ss(ss), .sclk(sclk), .mosi(mosi), .miso(miso)
   );

   spi_slave_model #(.seed(~seed)) slave_i (
      .SCK(SCK), .ss(ss), .sclk(sclk), .mosi(mosi), .miso(miso)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic int roll(input int n);
      rng = xorshift32(rng);
      return int'(rng % n);
   endfunction

   task automatic log_failure(input string msg);
      errors = errors + 1;
      $display("FAILED at %0t ns: %s", $time, msg);
   endtask

   // one strobe that the DUT takes when busy is low in its cycle
   task automatic issue_start(input spi_byte_t b, output bit acc);
      start   <= 1'b1;
      tx_data <= b;
      @(negedge SCK);
      acc = !busy;
      if (acc) begin
         tx_q.push_back(b);
         sent = sent + 1;
      end
      @(posedge SCK);
      start <= 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   initial begin
      bit acc;
      int total;
      repeat (5) @(posedge SCK);
      clr <= 1'b0;
      repeat (3) @(posedge SCK);
      while (sent < n_bytes) begin
         issue_start(spi_byte_t'(roll(256)), acc);
         if (acc && roll(3) == 0) begin
            issue_start(spi_byte_t'(roll(256)), acc);  // buffer just filled
            assert (!acc) else log_failure("start accepted while a byte was pending");
         end
         if (roll(12) == 0) begin
            repeat (64 + roll(16)) @(posedge SCK);  // late start so the engine may sit in hold
         end else begin
            repeat (roll(24)) @(posedge SCK);  // often queues behind a shift
         end
      end
      wait (done_cnt == sent);
      repeat (20) @(posedge SCK);
      assert (done_cnt == sent && tx_q.size() == 0)
         else log_failure($sformatf("%0d done pulses for %0d starts", done_cnt, sent));
      assert (slave_i.mosi_cnt == sent && slave_i.miso_cnt == sent)
         else log_failure($sformatf("slave framed %0d mosi and %0d miso bytes",
                                    slave_i.mosi_cnt, slave_i.miso_cnt));
      assert (ss && sclk && mosi) else log_failure("bus not idle at the end");
      total = errors + slave_i.idle_errors;
      $display("bytes sent %0d, done pulses %0d, errors %0d", sent, done_cnt, total);
      if (total == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // monitor sampled mid-cycle
   //////////////////////////////////////////////////////////////////////

   always @(negedge SCK) begin
      spi_byte_t want;
      cyc = cyc + 1;
      if (clr || clr_p) begin
         assert (ss && sclk && mosi && !busy && !done)
            else log_failure($sformatf("reset state ss %b sclk %b mosi %b busy %b done %b",
                                       ss, sclk, mosi, busy, done));
      end else begin
         if (done) begin
            assert (!done_p) else log_failure("done longer than one cycle");
            assert (tx_q.size() != 0) else log_failure("done without an accepted start");
            if (tx_q.size() != 0) begin
               want = tx_q.pop_front();
               assert (slave_i.mosi_log[done_cnt] == want)
                  else log_failure($sformatf("mosi byte %0d is %h, expected %h",
                                             done_cnt + 1, slave_i.mosi_log[done_cnt], want));
               assert (rx_data == slave_i.miso_log[done_cnt])
                  else log_failure($sformatf("rx_data %h, slave drove %h",
                                             rx_data, slave_i.miso_log[done_cnt]));
            end
            done_cnt = done_cnt + 1;
         end
         if (ss) begin
            assert (sclk) else log_failure("sclk low while ss is high");
         end
         if (sclk != sclk_p) begin
            if (!sclk_p || high_mid) begin
               assert (level_len == sclk_half)
                  else log_failure($sformatf("sclk level lasted %0d cycles", level_len));
            end
            if (sclk) begin
               rise_cnt = rise_cnt + 1;
               high_mid = (rise_cnt % 8 != 0);
               gap_ok   = !high_mid;  // eighth rise ends the byte
            end else begin
               gap_ok = 1'b0;
               if (fall_wait) begin
                  assert (cyc - fall_at == sclk_half)
                     else log_failure($sformatf("first fall %0d cycles after ss", cyc - fall_at));
                  fall_wait = 1'b0;
               end
            end
            level_len = 1;
         end else begin
            level_len = level_len + 1;
         end
         if (mosi != mosi_p) begin
            assert ((sclk_p && !sclk) || ss != ss_p || gap_ok)
               else log_failure("mosi changed without a falling sclk");
         end
         if (ss != ss_p) begin
            if (!ss) begin
               assert (done_cnt == 2 * ss_falls)
                  else log_failure($sformatf("ss fell after %0d done pulses", done_cnt));
               ss_falls  = ss_falls + 1;
               fall_at   = cyc;
               fall_wait = 1'b1;
               gap_ok    = 1'b0;
            end else begin
               ss_rises = ss_rises + 1;
               assert (done_cnt == 2 * ss_rises)
                  else log_failure($sformatf("ss rose after %0d done pulses", done_cnt));
               gap_ok = 1'b1;
            end
         end
      end
      clr_p  = clr;
      ss_p   = ss;
      sclk_p = sclk;
      mosi_p = mosi;
      done_p = done;
   end

   // hang guard
   initial begin
      repeat (wd_cycles) @(posedge SCK);
      $display("timeout after %0d cycles, %0d of %0d bytes done", wd_cycles, done_cnt, sent);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* spi_mode3.f */
spi_timing_pkg.sv
spi_data_pkg.sv
spi_tx_stage.sv
spi_shift_engine.sv
spi_rx_stage.sv
spi_mode3_top.sv
spi_slave_model.sv
tb_spi_mode3.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_spi_mode3
FILELIST   := spi_mode3.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
